// ==== Bender.yml ====
package:
  name: tilemap_layer

sources:
  - source/tilemap_pkg.sv
  - source/tilemap_fetch.sv
  - source/tile_pixel_unpack.sv
  - source/line_buffer.sv
  - source/tilemap_layer.sv
  - target: test
    files:
      - testbench/tilemap_mem_model.sv
      - testbench/tilemap_tb.sv

// ==== source/line_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// double line buffer
// renderer fills one bank while the
// display reads the other
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   swap,
    input  wire tilemap_pkg::pixel_wr_t wr,
    input  wire tilemap_pkg::buf_addr_t rd_addr,
    output tilemap_pkg::pixel_t         rd_pixel
);

    // both banks in one array, bank select on the top address bit
    tilemap_pkg::pixel_t mem [0:2*tilemap_pkg::buf_depth-1];

    logic rd_bank;   // bank on the display side
    logic wr_bank;

    assign wr_bank = ~rd_bank;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_bank <= 1'b0;
        end else if (swap) begin
            rd_bank <= ~rd_bank;   // finished line goes to display
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[{wr_bank, wr.addr}] <= wr.pixel;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_pixel <= mem[{rd_bank, rd_addr}];
    end

endmodule

`default_nettype wire

// ==== source/tile_pixel_unpack.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// planar graphics word unpacker
// four pixels per word into the line buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tile_pixel_unpack (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   line_start,
    input  wire tilemap_pkg::buf_addr_t start_addr,
    input  wire logic                   load,
    input  wire tilemap_pkg::mem_word_t load_word,
    input  wire logic [3:0]             load_pal,
    output logic                        shift_busy,
    output tilemap_pkg::pixel_wr_t      wr
);

    logic [2:0]             cnt;       // pixels left in the word
    logic                   we_q;
    tilemap_pkg::buf_addr_t addr_q;    // next write address
    tilemap_pkg::buf_addr_t waddr_q;
    tilemap_pkg::mem_word_t word_q;
    logic [3:0]             pal_q;
    tilemap_pkg::pixel_t    pix_q;

    // one bit from each plane
    function automatic logic [3:0] colour(input tilemap_pkg::mem_word_t w);
        return {w[12], w[8], w[4], w[0]};
    endfunction

    assign shift_busy = cnt != 3'd0;
    assign wr         = '{we: we_q, addr: waddr_q, pixel: pix_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= 3'd0;
            we_q <= 1'b0;
        end else if (line_start) begin
            cnt  <= 3'd0;
            we_q <= 1'b0;
        end else if (load) begin
            cnt  <= 3'd4;
            we_q <= 1'b0;
        end else begin
            we_q <= shift_busy;
            if (shift_busy) begin
                cnt <= cnt - 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_start) begin
            addr_q <= start_addr;
        end else if (load) begin
            word_q <= load_word;
            pal_q  <= load_pal;
        end else if (shift_busy) begin
            waddr_q <= addr_q;
            addr_q  <= addr_q + 9'd1;
            pix_q   <= {pal_q, colour(word_q)};
            word_q  <= word_q >> 1;   // next pixel into bit 0 of each plane
        end
    end

    // the fetch must wait out a word before sending the next one
    load_when_idle: assert property (@(posedge clk) disable iff (rst) load |-> !shift_busy)
        else $error("graphics word loaded while previous word still shifting");

endmodule

`default_nettype wire

// ==== source/tilemap_fetch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile layer fetch FSM
// walks the tile map and graphics ROM
// for one scroll-adjusted scan line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tilemap_fetch #(
    parameter int tile_size = 8   // 8, 16 or 32
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      line_start,
    input  wire tilemap_pkg::line_num_t    v,
    input  wire tilemap_pkg::scroll_regs_t regs,
    output logic                           vram_cs,
    output tilemap_pkg::vram_addr_t        vram_addr,
    input  wire tilemap_pkg::mem_word_t    vram_data,
    input  wire logic                      vram_ok,
    output logic                           rom_cs,
    output tilemap_pkg::rom_addr_t         rom_addr,
    input  wire tilemap_pkg::mem_word_t    rom_data,
    input  wire logic                      rom_ok,
    input  wire logic                      shift_busy,
    output logic                           load,
    output tilemap_pkg::mem_word_t         load_word,
    output logic [3:0]                     load_pal,
    output tilemap_pkg::buf_addr_t         start_addr,
    output logic                           line_done
);

    tilemap_pkg::fetch_state_t state;
    tilemap_pkg::scroll_t      base;
    tilemap_pkg::mem_word_t    code;
    tilemap_pkg::rom_addr_t    rom_word_addr;

    logic [10:0] vn;          // scrolled line
    logic [10:0] hn;          // scrolled column, steps of 4 pixels
    logic [2:0]  fine;        // fine horizontal scroll
    logic [9:0]  px_cnt;      // pixels handed to the unpacker
    logic [11:0] scan;        // tile index inside the map
    logic        tile_wrap;   // hn has moved into the next tile
    logic        line_end;

    // the first fine pixels land below address 0 and wrap out of view
    assign start_addr = 9'd0 - {6'd0, regs.hpos[2:0]};

    assign line_end = px_cnt >= (10'(tilemap_pkg::line_width) + {7'd0, fine});

    // map layout per tile size is upper row bits, six column bits, lower row bits
    generate
        case (tile_size)
            8: begin : g_tile8
                assign scan          = {vn[8], hn[8:3], vn[7:3]};
                assign rom_word_addr = {2'b00, code, vn[2:0], hn[2]};
                assign tile_wrap     = hn[2] == 1'b0;
            end
            16: begin : g_tile16
                assign scan          = {vn[9:8], hn[9:4], vn[7:4]};
                assign rom_word_addr = {code, vn[3:0], hn[3:2]};
                assign tile_wrap     = hn[3:2] == 2'b00;
            end
            default: begin : g_tile32
                assign scan          = {vn[10:8], hn[10:5], vn[7:5]};
                assign rom_word_addr = {code[13:0], vn[4:0], hn[4:2]};
                assign tile_wrap     = hn[4:2] == 3'b000;
            end
        endcase
    endgenerate

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= tilemap_pkg::fetch_idle;
            vram_cs   <= 1'b0;
            rom_cs    <= 1'b0;
            load      <= 1'b0;
            line_done <= 1'b0;
            px_cnt    <= 10'd0;
        end else begin
            load      <= 1'b0;   // single cycle pulses
            line_done <= 1'b0;
            if (line_start) begin   // also aborts a line in progress
                state   <= tilemap_pkg::fetch_scan;
                vram_cs <= 1'b0;
                rom_cs  <= 1'b0;
                px_cnt  <= 10'd0;
            end else begin
                case (state)
                    tilemap_pkg::fetch_scan: begin
                        vram_cs <= 1'b1;
                        state   <= tilemap_pkg::fetch_code_wait;
                    end
                    tilemap_pkg::fetch_code_wait: begin
                        if (vram_ok) begin
                            state <= tilemap_pkg::fetch_attr_wait;   // cs stays high
                        end
                    end
                    tilemap_pkg::fetch_attr_wait: begin
                        if (vram_ok) begin
                            vram_cs <= 1'b0;
                            state   <= tilemap_pkg::fetch_rom_req;
                        end
                    end
                    tilemap_pkg::fetch_rom_req: begin
                        rom_cs <= 1'b1;
                        state  <= tilemap_pkg::fetch_rom_wait;
                    end
                    tilemap_pkg::fetch_rom_wait: begin
                        if (rom_ok) begin
                            rom_cs <= 1'b0;
                            load   <= 1'b1;
                            px_cnt <= px_cnt + 10'd4;
                            state  <= tilemap_pkg::fetch_shift;
                        end
                    end
                    tilemap_pkg::fetch_shift: begin
                        // busy rises the cycle after load
                        if (!load && !shift_busy) begin
                            state <= tilemap_pkg::fetch_next;
                        end
                    end
                    tilemap_pkg::fetch_next: begin
                        if (line_end) begin
                            line_done <= 1'b1;
                            state     <= tilemap_pkg::fetch_idle;
                        end else if (tile_wrap) begin
                            state <= tilemap_pkg::fetch_scan;
                        end else begin
                            state <= tilemap_pkg::fetch_rom_req;
                        end
                    end
                    default: state <= tilemap_pkg::fetch_idle;
                endcase
            end
        end
    end

    // addresses, scroll copies and fetched words
    always_ff @(posedge clk) begin
        if (line_start) begin
            base <= regs.base;
            vn   <= regs.vpos[10:0] + {2'b00, v};
            hn   <= {regs.hpos[10:3], 3'b000};   // coarse part only
            fine <= regs.hpos[2:0];
        end else begin
            case (state)
                tilemap_pkg::fetch_scan: begin
                    vram_addr <= {base, 8'd0} + {11'd0, scan, 1'b0};
                end
                tilemap_pkg::fetch_code_wait: begin
                    if (vram_ok) begin
                        code         <= vram_data;
                        vram_addr[0] <= 1'b1;   // attribute follows code
                    end
                end
                tilemap_pkg::fetch_attr_wait: begin
                    if (vram_ok) begin
                        load_pal <= vram_data[3:0];
                    end
                end
                tilemap_pkg::fetch_rom_req: rom_addr <= rom_word_addr;
                tilemap_pkg::fetch_rom_wait: begin
                    if (rom_ok) begin
                        load_word <= rom_data;
                        hn        <= hn + 11'd4;
                    end
                end
                default: ;
            endcase
        end
    end

    // one memory request at a time on the shared bus
    single_select: assert property (@(posedge clk) disable iff (rst) !(vram_cs && rom_cs))
        else $error("video RAM and graphics ROM selected together");

endmodule

`default_nettype wire

// ==== source/tilemap_layer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scroll tile layer line renderer
// fetch, unpack and double line buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tilemap_layer #(
    parameter int tile_size = 8   // 8, 16 or 32
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      line_start,
    input  wire tilemap_pkg::line_num_t    v,
    input  wire tilemap_pkg::scroll_regs_t regs,
    output tilemap_pkg::vram_addr_t        vram_addr,
    output logic                           vram_cs,
    input  wire tilemap_pkg::mem_word_t    vram_data,
    input  wire logic                      vram_ok,
    output tilemap_pkg::rom_addr_t         rom_addr,
    output logic                           rom_cs,
    input  wire tilemap_pkg::mem_word_t    rom_data,
    input  wire logic                      rom_ok,
    input  wire tilemap_pkg::buf_addr_t    rd_addr,
    output tilemap_pkg::pixel_t            rd_pixel,
    output logic                           done
);

    logic                      load;
    tilemap_pkg::mem_word_t    load_word;
    logic [3:0]                load_pal;
    tilemap_pkg::buf_addr_t    start_addr;
    logic                      shift_busy;
    tilemap_pkg::pixel_wr_t    wr;

    tilemap_fetch #(
        .tile_size (tile_size)
    ) u_fetch (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .v          (v),
        .regs       (regs),
        .vram_cs    (vram_cs),
        .vram_addr  (vram_addr),
        .vram_data  (vram_data),
        .vram_ok    (vram_ok),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .shift_busy (shift_busy),
        .load       (load),
        .load_word  (load_word),
        .load_pal   (load_pal),
        .start_addr (start_addr),
        .line_done  (done)
    );

    tile_pixel_unpack u_unpack (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .start_addr (start_addr),
        .load       (load),
        .load_word  (load_word),
        .load_pal   (load_pal),
        .shift_busy (shift_busy),
        .wr         (wr)
    );

    // banks swap at the start of every line
    line_buffer u_line_buf (
        .clk      (clk),
        .rst      (rst),
        .swap     (line_start),
        .wr       (wr),
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel)
    );

endmodule

`default_nettype wire

// ==== source/tilemap_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile layer shared definitions
// widths, scroll and pixel write structs
// and the fetch FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package tilemap_pkg;

    localparam int line_width = 384;   // visible pixels per line
    localparam int buf_depth  = 512;   // entries per buffer bank
    localparam int vram_aw    = 24;    // video RAM word address
    localparam int rom_aw     = 22;    // graphics ROM word address

    typedef logic [vram_aw-1:0] vram_addr_t;
    typedef logic [rom_aw-1:0]  rom_addr_t;
    typedef logic [15:0]        mem_word_t;
    typedef logic [8:0]         line_num_t;
    typedef logic [15:0]        scroll_t;
    typedef logic [8:0]         buf_addr_t;

    // palette in [7:4], colour index in [3:0]
    typedef logic [7:0]         pixel_t;

    // layer registers, sampled at line start
    typedef struct packed {
        scroll_t base;   // tile map base in video RAM
        scroll_t hpos;   // horizontal scroll
        scroll_t vpos;   // vertical scroll
    } scroll_regs_t;

    // one line buffer write
    typedef struct packed {
        logic      we;     // write strobe
        buf_addr_t addr;   // buffer address
        pixel_t    pixel;  // pixel to store
    } pixel_wr_t;

    typedef enum logic [2:0] {
        fetch_idle,        // waiting for line start
        fetch_scan,        // form tile map address
        fetch_code_wait,   // tile code read
        fetch_attr_wait,   // attribute read
        fetch_rom_req,     // form graphics address
        fetch_rom_wait,    // graphics word read
        fetch_shift,       // pixels going out
        fetch_next         // next word, tile or end
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== sources.f ====
source/tilemap_pkg.sv
source/tilemap_fetch.sv
source/tile_pixel_unpack.sv
source/line_buffer.sv
source/tilemap_layer.sv
testbench/tilemap_mem_model.sv
testbench/tilemap_tb.sv

// ==== testbench/tilemap_mem_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory model for the tile layer
// video RAM or graphics ROM, address
// derived data and LFSR driven latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tilemap_mem_model #(
    parameter bit is_rom = 1'b0   // graphics ROM data pattern when set
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   random_lat,   // 0 gives a fixed single cycle
    input  wire logic [23:0]            addr,
    input  wire logic                   cs,
    output tilemap_pkg::mem_word_t      data,
    output logic                        ok
);

    logic [16:0] lfsr;
    logic [16:0] lfsr_1;   // one step ahead
    logic [16:0] lfsr_2;   // two steps ahead
    logic [2:0]  cnt;      // cycles left before ok
    logic        pend;     // request accepted

    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};   // x^17 + x^14 + 1
    endfunction

    function automatic tilemap_pkg::mem_word_t word_at(input logic [23:0] a);
        tilemap_pkg::mem_word_t w;
        if (is_rom) begin
            w = {a[7:0], a[15:8]} ^ {a[21:16], a[21:12]} ^ 16'hc3a5;
        end else begin
            w = {a[10:0], a[15:11]};   // low half rotated left by 5
        end
        return w;
    endfunction

    assign lfsr_1 = lfsr_step(lfsr);
    assign lfsr_2 = lfsr_step(lfsr_1);

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= 17'd87950;
            ok   <= 1'b0;
            pend <= 1'b0;
            cnt  <= 3'd0;
        end else if (!cs || ok) begin
            ok   <= 1'b0;   // word taken or request dropped
            pend <= 1'b0;
        end else if (!pend) begin
            pend <= 1'b1;
            if (random_lat) begin
                cnt  <= 3'd1 + {1'b0, lfsr_1[0], lfsr_2[0]};   // 1 to 4
                lfsr <= lfsr_2;
            end else begin
                cnt <= 3'd1;
            end
        end else if (cnt <= 3'd1) begin
            ok   <= 1'b1;
            data <= word_at(addr);
        end else begin
            cnt <= cnt - 3'd1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tilemap_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the tile layer renderer
// directed line renders checked against
// pixels computed from the map layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tilemap_tb;

    localparam int timeout_cycles = 10000;   // far above one line render

    logic                      clk;
    logic                      rst;
    logic                      line_start;
    logic                      random_lat;
    tilemap_pkg::line_num_t    v;
    tilemap_pkg::scroll_regs_t regs;
    tilemap_pkg::vram_addr_t   vram_addr;
    logic                      vram_cs;
    tilemap_pkg::mem_word_t    vram_data;
    logic                      vram_ok;
    tilemap_pkg::rom_addr_t    rom_addr;
    logic                      rom_cs;
    tilemap_pkg::mem_word_t    rom_data;
    logic                      rom_ok;
    tilemap_pkg::buf_addr_t    rd_addr;
    tilemap_pkg::pixel_t       rd_pixel;
    logic                      done;
    int                        done_count;
    int                        target_done;
    tilemap_pkg::pixel_t       captured [0:383];
    tilemap_pkg::pixel_t       fixed_img [0:383];   // line rendered at fixed latency

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            done_count <= 0;
        end else if (done) begin
            done_count <= done_count + 1;
        end
    end

    tilemap_layer #(.tile_size(8)) dut (
        .clk(clk), .rst(rst), .line_start(line_start), .v(v), .regs(regs),
        .vram_addr(vram_addr), .vram_cs(vram_cs), .vram_data(vram_data), .vram_ok(vram_ok),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
        .rd_addr(rd_addr), .rd_pixel(rd_pixel), .done(done)
    );

    tilemap_mem_model #(.is_rom(1'b0)) vram_model (
        .clk(clk), .rst(rst), .random_lat(random_lat), .addr(vram_addr),
        .cs(vram_cs), .data(vram_data), .ok(vram_ok)
    );

    tilemap_mem_model #(.is_rom(1'b1)) rom_model (
        .clk(clk), .rst(rst), .random_lat(random_lat), .addr({2'b00, rom_addr}),
        .cs(rom_cs), .data(rom_data), .ok(rom_ok)
    );

    function automatic tilemap_pkg::mem_word_t vram_word_of(input tilemap_pkg::vram_addr_t a);
        return {a[10:0], a[15:11]};
    endfunction

    function automatic tilemap_pkg::mem_word_t rom_word_of(input tilemap_pkg::rom_addr_t a);
        return {a[7:0], a[15:8]} ^ {a[21:16], a[21:12]} ^ 16'hc3a5;
    endfunction

    // 8 pixel tiles, map index {row[8], col[8:3], row[7:3]}, two words per tile
    function automatic tilemap_pkg::pixel_t expected_pixel(input int x,
            input tilemap_pkg::scroll_regs_t r, input tilemap_pkg::line_num_t lv);
        logic [10:0]             col;
        logic [10:0]             row;
        logic [11:0]             scan;
        tilemap_pkg::vram_addr_t code_addr;
        tilemap_pkg::mem_word_t  code;
        tilemap_pkg::mem_word_t  attr;
        tilemap_pkg::mem_word_t  w;
        int                      i;
        col       = r.hpos[10:0] + 11'(x);
        row       = r.vpos[10:0] + {2'b00, lv};
        scan      = {row[8], col[8:3], row[7:3]};
        code_addr = {r.base, 8'd0} + {11'd0, scan, 1'b0};
        code      = vram_word_of(code_addr);
        attr      = vram_word_of(code_addr + 24'd1);
        w         = rom_word_of({2'b00, code, row[2:0], col[2]});
        i         = int'(col[1:0]);   // pixel inside the word
        return {attr[3:0], w[12+i], w[8+i], w[4+i], w[i]};
    endfunction

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic start_line(input tilemap_pkg::line_num_t lv,
            input tilemap_pkg::scroll_regs_t r);
        @(negedge clk);
        line_start  = 1'b1;
        v           = lv;
        regs        = r;
        target_done = done_count + 1;
        @(negedge clk);
        line_start = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done_count < target_done && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        assert (done_count >= target_done) else begin
            $display("line render did not finish within %0d cycles", timeout_cycles);
            stop_run();
        end
    endtask

    // one address per cycle, data one cycle behind
    task automatic read_line();
        rd_addr = '0;
        for (int x = 0; x < tilemap_pkg::line_width; x++) begin
            @(negedge clk);
            captured[x] = rd_pixel;
            rd_addr     = 9'(x + 1);
        end
    endtask

    task automatic check_line(input tilemap_pkg::line_num_t lv,
            input tilemap_pkg::scroll_regs_t r);
        tilemap_pkg::pixel_t want;
        for (int x = 0; x < tilemap_pkg::line_width; x++) begin
            want = expected_pixel(x, r, lv);
            assert (captured[x] === want) else begin
                $display("MISMATCH rd_pixel at address %h: got %h, expected %h",
                         x, captured[x], want);
                stop_run();
            end
        end
    endtask

    // render, swap it to the display side, read while it renders again
    task automatic render_and_check(input tilemap_pkg::line_num_t lv,
            input tilemap_pkg::scroll_regs_t r);
        start_line(lv, r);
        wait_done();
        start_line(lv, r);
        read_line();
        check_line(lv, r);
        wait_done();
    endtask

    task automatic test_idle();
        repeat (40) begin
            @(negedge clk);
            assert (vram_cs === 1'b0 && rom_cs === 1'b0 && done === 1'b0) else begin
                $display("memory request or done seen without a line start");
                stop_run();
            end
        end
    endtask

    task automatic test_fine_scroll();
        tilemap_pkg::scroll_regs_t r;
        tilemap_pkg::pixel_t       want;
        r = '{base: 16'h0012, hpos: 16'h0003, vpos: 16'h0000};
        render_and_check(9'd0, r);
        // columns 0 to 2 go just below address 0, out of the visible line
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            rd_addr = 9'(509 + k);
            @(negedge clk);
            want = expected_pixel(k - 3, r, 9'd0);
            assert (rd_pixel === want) else begin
                $display("MISMATCH rd_pixel at address %h: got %h, expected %h",
                         509 + k, rd_pixel, want);
                stop_run();
            end
        end
    endtask

    task automatic test_vertical_scroll();
        tilemap_pkg::scroll_regs_t r;
        r = '{base: 16'h0031, hpos: 16'h0041, vpos: 16'h01f0};
        render_and_check(9'd5, r);
        render_and_check(9'd37, r);   // row crosses into the next page
        render_and_check(9'd130, r);
    endtask

    task automatic test_latency();
        tilemap_pkg::scroll_regs_t r;
        r          = '{base: 16'h0240, hpos: 16'h0105, vpos: 16'h0033};
        random_lat = 1'b0;
        render_and_check(9'd77, r);
        fixed_img  = captured;
        random_lat = 1'b1;
        start_line(9'd77, r);
        wait_done();
        start_line(9'd77, r);
        read_line();
        for (int x = 0; x < tilemap_pkg::line_width; x++) begin
            assert (captured[x] === fixed_img[x]) else begin
                $display("MISMATCH rd_pixel at address %h: random latency %h, fixed %h",
                         x, captured[x], fixed_img[x]);
                stop_run();
            end
        end
        wait_done();
    endtask

    task automatic test_double_buffer();
        tilemap_pkg::scroll_regs_t ra;
        tilemap_pkg::scroll_regs_t rb;
        ra = '{base: 16'h0100, hpos: 16'h0022, vpos: 16'h0000};
        rb = '{base: 16'h0380, hpos: 16'h0307, vpos: 16'h0055};
        start_line(9'd10, ra);
        wait_done();
        start_line(9'd200, rb);   // next line renders into the other bank
        read_line();
        check_line(9'd10, ra);
        wait_done();
        read_line();              // still the old line after the new one finished
        check_line(9'd10, ra);
        start_line(9'd200, rb);
        read_line();
        check_line(9'd200, rb);
        wait_done();
    endtask

    initial begin
        rst         = 1'b1;
        line_start  = 1'b0;
        random_lat  = 1'b1;
        v           = '0;
        regs        = '0;
        rd_addr     = '0;
        target_done = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        test_idle();
        render_and_check(9'd0, '{base: 16'h0012, hpos: 16'h0000, vpos: 16'h0000});
        test_fine_scroll();
        test_vertical_scroll();
        test_latency();
        test_double_buffer();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
